// File: hdl/rv_pkg.sv
package rv_pkg;

  localparam int xlen        = 32;
  localparam int reg_addr_w  = 5;
  localparam int bht_index_w = 8;
  localparam int bht_entries = 1 << bht_index_w;
  localparam int hist_w      = 2;
  localparam int btb_tag_w   = xlen - bht_index_w;

  localparam logic [6:0] op_op     = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;

  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;
  localparam logic [2:0] f3_beq     = 3'b000;
  localparam logic [2:0] f3_bne     = 3'b001;
  localparam logic [2:0] f3_blt     = 3'b100;
  localparam logic [6:0] f7_sub     = 7'b0100000;

  // weakly not taken
  localparam logic [1:0] ctr_weak_nt = 2'b01;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0]           imm12;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } i_view_t;

  // rd holds immediate bits for branches
  typedef struct packed {
    logic [6:0]            imm_hi;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } bj_view_t;

  typedef union packed {
    r_view_t  r;
    i_view_t  i;
    bj_view_t bj;
  } instr_u;

endpackage

// File: hdl/rv_ifs.sv
`timescale 1ns/1ps

interface fd_if import rv_pkg::*; ();
  logic              valid;
  logic [xlen-1:0]   pc;
  instr_u            instr;
  logic [xlen-1:0]   pred_pc;
  logic [hist_w-1:0] hist;

  modport src (output valid, pc, instr, pred_pc, hist);
  modport dst (input valid, pc, instr, pred_pc, hist);
endinterface

interface dx_if import rv_pkg::*; ();
  logic              valid;
  logic [xlen-1:0]   pc;
  instr_u            instr;
  logic [xlen-1:0]   op_a;
  logic [xlen-1:0]   op_b;
  logic [xlen-1:0]   imm;
  logic [xlen-1:0]   pred_pc;
  logic [hist_w-1:0] hist;

  modport src (output valid, pc, instr, op_a, op_b, imm, pred_pc, hist);
  modport dst (input valid, pc, instr, op_a, op_b, imm, pred_pc, hist);
endinterface

interface resolve_if import rv_pkg::*; ();
  logic              upd;
  logic [xlen-1:0]   pc;
  logic              taken;
  logic [xlen-1:0]   target;
  logic [hist_w-1:0] hist;
  logic              mispredict;
  logic [xlen-1:0]   redirect_pc;

  modport exe (output upd, pc, taken, target, hist, mispredict, redirect_pc);
  modport fe (input upd, pc, taken, target, hist, mispredict, redirect_pc);
endinterface

// File: hdl/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor import rv_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  input  logic [xlen-1:0]   pc,
  input  logic              is_branch,
  output logic [xlen-1:0]   pred_pc,
  output logic [hist_w-1:0] hist,
  resolve_if.fe             res
);

  logic [1:0]           ctr        [bht_entries][1 << hist_w];
  logic                 btb_valid  [bht_entries];
  logic [btb_tag_w-1:0] btb_tag    [bht_entries];
  logic [xlen-1:0]      btb_target [bht_entries];
  logic [hist_w-1:0]    ghist;

  logic [bht_index_w-1:0] idx;
  logic [bht_index_w-1:0] upd_idx;
  logic                   btb_hit;
  logic [1:0]             upd_ctr;

  assign idx     = pc[bht_index_w-1:0];
  assign upd_idx = res.pc[bht_index_w-1:0];
  assign btb_hit = btb_valid[idx] && (btb_tag[idx] == pc[xlen-1:bht_index_w]);

  // taken only on a strong-enough counter and a known target
  assign pred_pc = (is_branch && ctr[idx][ghist][1] && btb_hit) ? btb_target[idx] : pc + 1;
  assign hist    = ghist;

  assign upd_ctr = ctr[upd_idx][res.hist];

  always_ff @(posedge clk) begin
    if (rstn) begin
      ghist <= '0;
      for (int e = 0; e < bht_entries; e++) begin
        for (int h = 0; h < (1 << hist_w); h++) begin
          ctr[e][h] <= ctr_weak_nt;
        end
        btb_valid[e]  <= 1'b0;
        btb_tag[e]    <= '0;
        btb_target[e] <= '0;
      end
    end else if (res.upd) begin
      ghist <= {ghist[hist_w-2:0], res.taken};
      if (res.taken) begin
        ctr[upd_idx][res.hist] <= (upd_ctr == 2'b11) ? upd_ctr : upd_ctr + 2'b01;
        btb_valid[upd_idx]     <= 1'b1;
        btb_tag[upd_idx]       <= res.pc[xlen-1:bht_index_w];
        btb_target[upd_idx]    <= res.target;
      end else begin
        ctr[upd_idx][res.hist] <= (upd_ctr == 2'b00) ? upd_ctr : upd_ctr - 2'b01;
      end
    end
  end

endmodule

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import rv_pkg::*; (
  input  logic            clk,
  input  logic            rstn,
  output logic [xlen-1:0] imem_addr,
  input  logic [xlen-1:0] imem_data,
  fd_if.src               fd,
  resolve_if.fe           res
);

  logic [xlen-1:0]   pc;
  logic [xlen-1:0]   pred_pc;
  logic [hist_w-1:0] hist;
  instr_u            fetched;
  logic              is_branch;

  assign imem_addr = pc;
  assign fetched   = imem_data;
  // only control flow consults the predictor
  assign is_branch = (fetched.r.opcode == op_branch) || (fetched.r.opcode == op_jal);

  branch_predictor i_bp (
    .clk       (clk),
    .rstn      (rstn),
    .pc        (pc),
    .is_branch (is_branch),
    .pred_pc   (pred_pc),
    .hist      (hist),
    .res       (res)
  );

  always_ff @(posedge clk) begin
    if (rstn) begin
      pc       <= '0;
      fd.valid <= 1'b0;
    end else if (res.mispredict) begin
      // word in flight is on the wrong path
      pc       <= res.redirect_pc;
      fd.valid <= 1'b0;
    end else begin
      pc       <= pred_pc;
      fd.valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    fd.pc      <= pc;
    fd.instr   <= fetched;
    fd.pred_pc <= pred_pc;
    fd.hist    <= hist;
  end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic [reg_addr_w-1:0] rs1,
  input  logic [reg_addr_w-1:0] rs2,
  output logic [xlen-1:0]       rs1_data,
  output logic [xlen-1:0]       rs2_data,
  input  logic                  we,
  input  logic [reg_addr_w-1:0] rd,
  input  logic [xlen-1:0]       wd
);

  logic [xlen-1:0] regs [1 << reg_addr_w];

  // x0 is hardwired, same-cycle write passes through
  assign rs1_data = (rs1 == '0) ? '0 : (we && rd == rs1) ? wd : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : (we && rd == rs2) ? wd : regs[rs2];

  always_ff @(posedge clk) begin
    if (rstn) begin
      for (int r = 0; r < (1 << reg_addr_w); r++) begin
        regs[r] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wd;
    end
  end

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rstn,
  fd_if.dst                     fd,
  dx_if.src                     dx,
  input  logic                  flush,
  input  logic                  fwd_valid,
  input  logic [reg_addr_w-1:0] fwd_rd,
  input  logic [xlen-1:0]       fwd_data,
  input  logic                  wb_we,
  input  logic [reg_addr_w-1:0] wb_rd,
  input  logic [xlen-1:0]       wb_data
);

  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] imm;
  logic [19:0]     upper;

  reg_file i_rf (
    .clk      (clk),
    .rstn     (rstn),
    .rs1      (fd.instr.r.rs1),
    .rs2      (fd.instr.r.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (wb_we),
    .rd       (wb_rd),
    .wd       (wb_data)
  );

  assign upper = {fd.instr.bj.imm_hi, fd.instr.bj.rs2, fd.instr.bj.rs1, fd.instr.bj.funct3};

  always_comb begin
    case (fd.instr.r.opcode)
      op_imm:    imm = {{20{fd.instr.i.imm12[11]}}, fd.instr.i.imm12};
      op_lui:    imm = {upper, 12'b0};
      op_branch: imm = {{19{fd.instr.bj.imm_hi[6]}}, fd.instr.bj.imm_hi[6], fd.instr.bj.rd[0],
                        fd.instr.bj.imm_hi[5:0], fd.instr.bj.rd[4:1], 1'b0};
      op_jal:    imm = {{11{upper[19]}}, upper[19], upper[7:0], upper[8], upper[18:9], 1'b0};
      default:   imm = '0;
    endcase
  end

  // bypass the result execute is producing now
  assign op_a = (fwd_valid && fwd_rd != '0 && fwd_rd == fd.instr.r.rs1) ? fwd_data : rs1_data;
  assign op_b = (fwd_valid && fwd_rd != '0 && fwd_rd == fd.instr.r.rs2) ? fwd_data : rs2_data;

  always_ff @(posedge clk) begin
    if (rstn) begin
      dx.valid <= 1'b0;
    end else begin
      dx.valid <= fd.valid && !flush;
    end
  end

  always_ff @(posedge clk) begin
    dx.pc      <= fd.pc;
    dx.instr   <= fd.instr;
    dx.op_a    <= op_a;
    dx.op_b    <= op_b;
    dx.imm     <= imm;
    dx.pred_pc <= fd.pred_pc;
    dx.hist    <= fd.hist;
  end

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rstn,
  dx_if.dst                     dx,
  resolve_if.exe                res,
  output logic                  fwd_valid,
  output logic [reg_addr_w-1:0] fwd_rd,
  output logic [xlen-1:0]       fwd_data,
  output logic                  wb_we,
  output logic [reg_addr_w-1:0] wb_rd,
  output logic [xlen-1:0]       wb_data,
  output logic                  retire_valid,
  output logic [xlen-1:0]       retire_pc,
  output logic [xlen-1:0]       branch_count,
  output logic [xlen-1:0]       mispredict_count
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [xlen-1:0] src_b;
  logic [xlen-1:0] alu;
  logic [xlen-1:0] result;
  logic [xlen-1:0] next_pc;
  logic            is_br;
  logic            is_jal;
  logic            cond;
  logic            taken;
  logic            writes;

  assign opcode = dx.instr.r.opcode;
  assign funct3 = dx.instr.r.funct3;
  assign is_br  = (opcode == op_branch);
  assign is_jal = (opcode == op_jal);
  assign src_b  = (opcode == op_op) ? dx.op_b : dx.imm;

  always_comb begin
    case (funct3)
      f3_add_sub: alu = (opcode == op_op && dx.instr.r.funct7 == f7_sub) ?
                        dx.op_a - src_b : dx.op_a + src_b;
      f3_slt:     alu = {{(xlen-1){1'b0}}, $signed(dx.op_a) < $signed(src_b)};
      f3_xor:     alu = dx.op_a ^ src_b;
      f3_or:      alu = dx.op_a | src_b;
      f3_and:     alu = dx.op_a & src_b;
      default:    alu = dx.op_a + src_b;
    endcase
  end

  // jal links the following word
  assign result = is_jal ? dx.pc + 1 : (opcode == op_lui) ? dx.imm : alu;

  always_comb begin
    case (funct3)
      f3_beq:  cond = (dx.op_a == dx.op_b);
      f3_bne:  cond = (dx.op_a != dx.op_b);
      f3_blt:  cond = ($signed(dx.op_a) < $signed(dx.op_b));
      default: cond = 1'b0;
    endcase
  end

  assign taken   = is_jal || (is_br && cond);
  assign next_pc = taken ? dx.pc + dx.imm : dx.pc + 1;

  assign res.upd         = dx.valid && (is_br || is_jal);
  assign res.pc          = dx.pc;
  assign res.taken       = taken;
  assign res.target      = dx.pc + dx.imm;
  assign res.hist        = dx.hist;
  assign res.mispredict  = res.upd && (next_pc != dx.pred_pc);
  assign res.redirect_pc = next_pc;

  assign writes = dx.valid && dx.instr.r.rd != '0 &&
                  (opcode == op_op || opcode == op_imm || opcode == op_lui || is_jal);

  assign fwd_valid = writes;
  assign fwd_rd    = dx.instr.r.rd;
  assign fwd_data  = result;

  always_ff @(posedge clk) begin
    if (rstn) begin
      retire_valid     <= 1'b0;
      wb_we            <= 1'b0;
      branch_count     <= '0;
      mispredict_count <= '0;
    end else begin
      retire_valid <= dx.valid;
      wb_we        <= writes;
      if (res.upd) begin
        branch_count <= branch_count + 1;
      end
      if (res.mispredict) begin
        mispredict_count <= mispredict_count + 1;
      end
    end
  end

  always_ff @(posedge clk) begin
    retire_pc <= dx.pc;
    wb_rd     <= dx.instr.r.rd;
    wb_data   <= result;
  end

endmodule

// File: hdl/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rstn,
  output logic [xlen-1:0]       imem_addr,
  input  logic [xlen-1:0]       imem_data,
  output logic                  retire_valid,
  output logic [xlen-1:0]       retire_pc,
  output logic                  retire_we,
  output logic [reg_addr_w-1:0] retire_rd,
  output logic [xlen-1:0]       retire_data,
  output logic [xlen-1:0]       branch_count,
  output logic [xlen-1:0]       mispredict_count
);

  fd_if      fd_bus ();
  dx_if      dx_bus ();
  resolve_if res_bus ();

  logic                  fwd_valid;
  logic [reg_addr_w-1:0] fwd_rd;
  logic [xlen-1:0]       fwd_data;

  fetch_stage i_fetch (
    .clk       (clk),
    .rstn      (rstn),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .fd        (fd_bus),
    .res       (res_bus)
  );

  // write-back port doubles as the retire outputs
  decode_stage i_decode (
    .clk       (clk),
    .rstn      (rstn),
    .fd        (fd_bus),
    .dx        (dx_bus),
    .flush     (res_bus.mispredict),
    .fwd_valid (fwd_valid),
    .fwd_rd    (fwd_rd),
    .fwd_data  (fwd_data),
    .wb_we     (retire_we),
    .wb_rd     (retire_rd),
    .wb_data   (retire_data)
  );

  execute_stage i_execute (
    .clk              (clk),
    .rstn             (rstn),
    .dx               (dx_bus),
    .res              (res_bus),
    .fwd_valid        (fwd_valid),
    .fwd_rd           (fwd_rd),
    .fwd_data         (fwd_data),
    .wb_we            (retire_we),
    .wb_rd            (retire_rd),
    .wb_data          (retire_data),
    .retire_valid     (retire_valid),
    .retire_pc        (retire_pc),
    .branch_count     (branch_count),
    .mispredict_count (mispredict_count)
  );

endmodule

// File: tb/core_asserts.sv
`timescale 1ns/1ps

module core_asserts import rv_pkg::*; (
  input logic                  clk,
  input logic                  rstn,
  input logic                  retire_valid,
  input logic                  retire_we,
  input logic [reg_addr_w-1:0] retire_rd,
  input logic [xlen-1:0]       branch_count,
  input logic [xlen-1:0]       mispredict_count
);

  a_retire_after_reset: assert property (@(posedge clk) rstn |=> !retire_valid)
    else $error("retire_valid high in the cycle after reset");

  a_we_rd_nonzero: assert property (@(posedge clk) disable iff (rstn)
    retire_we |-> retire_rd != '0)
    else $error("retire_we with rd zero");

  a_misp_bounded: assert property (@(posedge clk) disable iff (rstn)
    mispredict_count <= branch_count)
    else $error("mispredict_count above branch_count");

  // counters only move up once out of reset
  a_counters_monotonic: assert property (@(posedge clk) disable iff (rstn)
    $past(!rstn) |-> (branch_count >= $past(branch_count) &&
                      mispredict_count >= $past(mispredict_count)))
    else $error("counter decreased");

endmodule

// File: tb/tb_core.sv
`timescale 1ns/1ps

module tb_core import rv_pkg::*; ();

  logic clk;
  logic rstn;
  logic [31:0] imem_addr, imem_data, retire_pc, retire_data, branch_count, mispredict_count;
  logic retire_valid, retire_we;
  logic [4:0] retire_rd;

  logic [31:0] rom [256];
  logic [31:0] model_regs [32];
  logic [31:0] model_pc, halt_pc, model_branches, final_branch, final_misp;
  logic [31:0] m_npc, m_data;
  logic m_we;
  logic [4:0] m_rd;
  int cursor, errors, total_instr, tests_started, cycles;
  integer seed;
  logic checking, done;
  string test_name;

  rv_core i_dut (.*);

  bind rv_core core_asserts i_asserts (.*);

  assign imem_data = rom[imem_addr[7:0]];

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                        logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_jal(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // one instruction of the ISA on the model register file
  function automatic void step_model(input logic [31:0] pc, output logic [31:0] npc,
                                     output logic we, output logic [4:0] rd,
                                     output logic [31:0] data);
    logic [31:0] i, a, b, bimm, jimm;
    logic cond;
    i = rom[pc[7:0]];
    rd = i[11:7];
    a = model_regs[i[19:15]];
    b = model_regs[i[24:20]];
    bimm = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
    jimm = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
    npc = pc + 1;
    we = 1'b0;
    data = '0;
    case (i[6:0])
      7'b0110011: begin
        we = 1'b1;
        case (i[14:12])
          3'b000: data = (i[31:25] == 7'b0100000) ? a - b : a + b;
          3'b010: data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'b100: data = a ^ b;
          3'b110: data = a | b;
          default: data = a & b;
        endcase
      end
      7'b0010011: begin
        we = 1'b1;
        data = a + {{20{i[31]}}, i[31:20]};
      end
      7'b0110111: begin
        we = 1'b1;
        data = {i[31:12], 12'b0};
      end
      7'b1100011: begin
        model_branches++;
        cond = (i[14:12] == 3'b000) ? (a == b) :
               (i[14:12] == 3'b001) ? (a != b) : ($signed(a) < $signed(b));
        if (cond) npc = pc + bimm;
      end
      default: begin
        model_branches++;
        we = 1'b1;
        data = pc + 1;
        npc = pc + jimm;
      end
    endcase
    if (rd == 0) we = 1'b0;
    if (we) model_regs[rd] = data;
  endfunction

  task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic reset_model();
    for (int r = 0; r < 32; r++) model_regs[r] = '0;
    model_pc = 0;
    model_branches = 0;
  endtask

  task automatic put(logic [31:0] w);
    rom[cursor] = w;
    cursor++;
  endtask

  task automatic start_program();
    @(negedge clk);
    rstn = 1'b1;
    checking = 1'b0;
    // nop fill that still varies with the address
    for (int a = 0; a < 256; a++) rom[a] = enc_addi(5'd0, 5'd0, 12'(a * 37 + 5));
    cursor = 0;
    repeat (10) @(negedge clk);
  endtask

  task automatic run_program(string name, bit is_loop);
    int n;
    halt_pc = cursor;
    put(enc_jal(5'd0, 21'd0));
    test_name = name;
    reset_model();
    n = 0;
    while (model_pc != halt_pc && n < 10000) begin
      step_model(model_pc, m_npc, m_we, m_rd, m_data);
      model_pc = m_npc;
      n++;
    end
    total_instr += n;
    tests_started++;
    reset_model();
    done = 1'b0;
    checking = 1'b1;
    rstn = 1'b0;
    wait (done);
    check_value("branch_count", model_branches, final_branch);
    if (is_loop && (final_misp < 1 || final_misp > 4)) begin
      errors++;
      $display("Fail %s mispredict_count: expected 1 to 4, actual %0d", name, final_misp);
    end
  endtask

  always @(negedge clk) begin
    if (checking && retire_valid) begin
      step_model(model_pc, m_npc, m_we, m_rd, m_data);
      check_value("retire_pc", model_pc, retire_pc);
      check_value("retire_we", {31'b0, m_we}, {31'b0, retire_we});
      if (m_we) begin
        check_value("retire_rd", {27'b0, m_rd}, {27'b0, retire_rd});
        check_value("retire_data", m_data, retire_data);
      end
      model_pc = m_npc;
      if (model_pc == halt_pc) begin
        final_branch = branch_count;
        final_misp = mispredict_count;
        checking = 1'b0;
        done = 1'b1;
      end
    end
  end

  // budget grows as each test is started
  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > 4 * total_instr + 100 + 12 * (tests_started + 1)) begin
        $display("Error: the run timed out before the programs finished");
        $display("errors: %0d", errors + 1);
        $display("*** TEST FAILED ***");
        $finish;
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic [4:0] rd, rs1, rs2;
    logic [2:0] f3s [6];
    rstn = 1'b1;
    checking = 1'b0;
    done = 1'b0;
    errors = 0;
    total_instr = 0;
    tests_started = 0;
    seed = 70;
    f3s = '{3'b000, 3'b000, 3'b010, 3'b100, 3'b110, 3'b111};

    start_program();
    for (int k = 1; k < 8; k++) begin
      put({32'($random(seed)) & 32'hffff_f000} | {20'b0, 5'(k), 7'b0110111});
      put(enc_addi(5'(k), 5'(k), 12'($random(seed))));
    end
    for (int k = 0; k < 30; k++) begin
      r = $random(seed);
      rd = 5'(1 + r[7:0] % 7);
      rs1 = 5'(r[10:8]);
      rs2 = 5'(r[13:11]);
      case (r[18:16] % 8)
        0: put(enc_addi(rd, rs1, r[31:20]));
        1: put({r[31:12], rd, 7'b0110111});
        2: put(enc_r(f7_sub, rs2, rs1, 3'b000, rd));
        default: put(enc_r(7'b0, rs2, rs1, f3s[r[23:21] % 6], rd));
      endcase
    end
    run_program("arith", 1'b0);

    start_program();
    put(enc_addi(5'd1, 5'd0, 12'd5));
    put(enc_addi(5'd2, 5'd1, 12'd3));
    put(enc_r(7'b0, 5'd1, 5'd2, 3'b000, 5'd3));
    put(enc_r(f7_sub, 5'd2, 5'd3, 3'b000, 5'd4));
    put(enc_r(7'b0, 5'd3, 5'd4, 3'b100, 5'd5));
    put(enc_addi(5'd9, 5'd0, 12'hff4));
    put(enc_addi(5'd6, 5'd0, 12'd1));
    put(enc_r(7'b0, 5'd6, 5'd9, 3'b010, 5'd7));
    put(enc_r(7'b0, 5'd6, 5'd9, 3'b110, 5'd8));
    run_program("forwarding", 1'b0);

    start_program();
    put(enc_addi(5'd1, 5'd0, 12'd5));
    put(enc_addi(5'd2, 5'd0, 12'd5));
    put(enc_addi(5'd3, 5'd0, 12'hffd));
    put(enc_b(f3_beq, 5'd1, 5'd2, 13'd4));
    for (int k = 0; k < 3; k++) put(enc_addi(5'd10, 5'd0, 12'(k + 1)));
    put(enc_b(f3_bne, 5'd1, 5'd2, 13'd2));
    put(enc_addi(5'd11, 5'd0, 12'd7));
    put(enc_b(f3_blt, 5'd3, 5'd1, 13'd4));
    for (int k = 0; k < 3; k++) put(enc_addi(5'd11, 5'd0, 12'(k + 1)));
    put(enc_b(f3_blt, 5'd1, 5'd3, 13'd2));
    put(enc_b(f3_bne, 5'd1, 5'd3, 13'd2));
    put(enc_addi(5'd12, 5'd0, 12'd1));
    put(enc_b(f3_beq, 5'd1, 5'd3, 13'd2));
    put(enc_jal(5'd5, 21'd4));
    for (int k = 0; k < 3; k++) put(enc_addi(5'd13, 5'd0, 12'(k + 1)));
    put(enc_r(7'b0, 5'd11, 5'd5, 3'b000, 5'd14));
    run_program("branches", 1'b0);

    start_program();
    put(enc_addi(5'd1, 5'd0, 12'd20));
    put(enc_addi(5'd2, 5'd0, 12'd0));
    put(enc_addi(5'd2, 5'd2, 12'd3));
    put(enc_r(7'b0, 5'd1, 5'd2, 3'b100, 5'd3));
    put(enc_r(7'b0, 5'd3, 5'd4, 3'b000, 5'd4));
    put(enc_addi(5'd1, 5'd1, 12'hfff));
    put(enc_b(f3_bne, 5'd1, 5'd0, 13'h1ffc));
    run_program("loop", 1'b1);

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: rv_core.f
hdl/rv_pkg.sv
hdl/rv_ifs.sv
hdl/branch_predictor.sv
hdl/fetch_stage.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/rv_core.sv
tb/core_asserts.sv
tb/tb_core.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator
verilator --binary --assert -Wno-fatal -f rv_core.f --top-module tb_core -o sim_core \
  && ./obj_dir/sim_core | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
